// ==== source/div_pkg.sv ====
package div_pkg;

    // datapath and pipeline field widths
    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int fu_type_w = 4;

    // functional unit code routed to the divider
    localparam logic [fu_type_w-1:0] fu_div = 4'd2;

    // operation subtype, same encoding as the issue stage
    typedef enum logic [4:0] {
        op_div  = 5'd0,
        op_mod  = 5'd1,
        op_divu = 5'd2,
        op_modu = 5'd3
    } div_op_e;

    // issue stage payload
    typedef struct packed {
        logic                 valid;
        logic [fu_type_w-1:0] fu_type;
        div_op_e              op;
        logic [xlen-1:0]      src1;
        logic [xlen-1:0]      src2;
        logic [reg_idx_w-1:0] rd;
    } exec_issue_t;

    // writeback stage payload
    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      result;
    } div_wb_t;

    // divider core FSM
    typedef enum logic [1:0] {
        st_idle,
        st_align,
        st_iter,
        st_hold
    } div_state_e;

endpackage

// ==== source/lead_one_finder.sv ====
`timescale 1ns/1ps

module lead_one_finder (
    input  logic [div_pkg::xlen-1:0] data,
    output logic [4:0]               msb_index
);
    logic [15:0] d16;
    logic [7:0]  d8;
    logic [3:0]  d4;
    logic [1:0]  d2;

    // halve the window at each level, keep the upper half if it has a one
    always_comb
    begin
        msb_index[4] = |data[31:16];
        if (msb_index[4])
            d16 = data[31:16];
        else
            d16 = data[15:0];

        msb_index[3] = |d16[15:8];
        if (msb_index[3])
            d8 = d16[15:8];
        else
            d8 = d16[7:0];

        msb_index[2] = |d8[7:4];
        if (msb_index[2])
            d4 = d8[7:4];
        else
            d4 = d8[3:0];

        msb_index[1] = |d4[3:2];
        if (msb_index[1])
            d2 = d4[3:2];
        else
            d2 = d4[1:0];

        // zero input falls through to index 0
        msb_index[0] = d2[1];
    end

endmodule

// ==== source/div_pipe_reg.sv ====
`timescale 1ns/1ps

module div_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush wins over stall so a killed entry never lingers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            q <= '0;
        end
        else if (flush)
        begin
            q <= '0;
        end
        else if (!stall)
        begin
            q <= d;
        end
    end

endmodule

// ==== source/div_core.sv ====
`timescale 1ns/1ps

module div_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 out_stall,
    input  div_pkg::exec_issue_t req,
    output logic                 busy,
    output div_pkg::div_wb_t     done_out
);
    import div_pkg::*;

    div_state_e state_q;
    div_state_e state_d;

    logic [xlen-1:0]      rem_q;
    logic [xlen-1:0]      rem_d;
    logic [xlen-1:0]      quo_q;
    logic [xlen-1:0]      quo_d;
    logic [xlen-1:0]      dvs_q;
    logic [xlen-1:0]      dvs_d;
    logic [5:0]           shift_q;
    logic [5:0]           shift_d;
    div_op_e              op_q;
    div_op_e              op_d;
    logic [reg_idx_w-1:0] rd_q;
    logic [reg_idx_w-1:0] rd_d;
    logic                 a_sign_q;
    logic                 a_sign_d;
    logic                 b_sign_q;
    logic                 b_sign_d;

    logic                 accept;
    logic                 fin;
    logic [xlen-1:0]      a_mag;
    logic [xlen-1:0]      b_mag;
    logic [4:0]           rem_msb;
    logic [4:0]           dvs_msb;
    logic [5:0]           shift_calc;
    logic [xlen:0]        diff;

    function automatic logic op_signed(div_op_e op);
        return (op == op_div) || (op == op_mod);
    endfunction

    lead_one_finder u_rem_lof (
        .data      (rem_q),
        .msb_index (rem_msb)
    );

    lead_one_finder u_dvs_lof (
        .data      (dvs_q),
        .msb_index (dvs_msb)
    );

    assign accept = (state_q == st_idle) && req.valid && (req.fu_type == fu_div)
                    && !out_stall;

    // magnitudes for signed ops, raw operands otherwise
    assign a_mag = (op_signed(req.op) && req.src1[xlen-1]) ? -req.src1 : req.src1;
    assign b_mag = (op_signed(req.op) && req.src2[xlen-1]) ? -req.src2 : req.src2;

    // negative result means divisor already exceeds dividend
    assign shift_calc = {1'b0, rem_msb} - {1'b0, dvs_msb};

    // borrow in the top bit says the shifted divisor does not fit
    assign diff = {1'b0, rem_q} - ({1'b0, dvs_q} << shift_q);

    // busy drops as soon as the held result can leave
    assign busy = (state_q != st_idle) && !((state_q == st_hold) && !out_stall);

    always_comb
    begin
        state_d  = state_q;
        rem_d    = rem_q;
        quo_d    = quo_q;
        dvs_d    = dvs_q;
        shift_d  = shift_q;
        op_d     = op_q;
        rd_d     = rd_q;
        a_sign_d = a_sign_q;
        b_sign_d = b_sign_q;
        fin      = 1'b0;

        case (state_q)
            st_idle:
            begin
                if (accept)
                begin
                    state_d  = st_align;
                    rem_d    = a_mag;
                    dvs_d    = b_mag;
                    quo_d    = '0;
                    op_d     = req.op;
                    rd_d     = req.rd;
                    a_sign_d = req.src1[xlen-1];
                    b_sign_d = req.src2[xlen-1];
                end
            end
            st_align:
            begin
                // zero divisor leaves the dividend as remainder
                if ((dvs_q == '0) || shift_calc[5])
                begin
                    fin = 1'b1;
                end
                else
                begin
                    state_d = st_iter;
                    shift_d = shift_calc;
                end
            end
            st_iter:
            begin
                quo_d = {quo_q[xlen-2:0], ~diff[xlen]};
                if (!diff[xlen])
                    rem_d = diff[xlen-1:0];
                if (shift_q == 6'd0)
                    fin = 1'b1;
                else
                    shift_d = shift_q - 6'd1;
            end
            st_hold:
            begin
                if (!out_stall)
                    state_d = st_idle;
            end
            default:
            begin
                state_d = st_idle;
            end
        endcase

        // remainder follows the dividend sign, quotient the sign product
        if (fin)
        begin
            state_d = st_hold;
            if (op_signed(op_q) && a_sign_q)
                rem_d = -rem_d;
            if (op_signed(op_q) && (a_sign_q ^ b_sign_q))
                quo_d = -quo_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= st_idle;
        end
        else if (flush)
        begin
            state_q <= st_idle;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk)
    begin
        rem_q    <= rem_d;
        quo_q    <= quo_d;
        dvs_q    <= dvs_d;
        shift_q  <= shift_d;
        op_q     <= op_d;
        rd_q     <= rd_d;
        a_sign_q <= a_sign_d;
        b_sign_q <= b_sign_d;
    end

    always_comb
    begin
        done_out.valid = (state_q == st_hold);
        done_out.rd    = rd_q;
        if ((op_q == op_div) || (op_q == op_divu))
            done_out.result = quo_q;
        else
            done_out.result = rem_q;
    end

endmodule

// ==== source/exec_div_top.sv ====
`timescale 1ns/1ps

module exec_div_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  div_pkg::exec_issue_t issue_in,
    input  logic                 ex_stall,
    input  logic                 ex_flush,
    input  logic                 wb_stall,
    input  logic                 wb_flush,
    output logic                 div_busy,
    output div_pkg::div_wb_t     wb_out
);
    import div_pkg::*;

    exec_issue_t issue_q;
    div_wb_t     done_out;
    logic        issue_stall;

    // hold the request in place while the core works
    assign issue_stall = ex_stall | div_busy;

    div_pipe_reg #(
        .payload_t (exec_issue_t)
    ) u_issue_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (issue_stall),
        .flush (ex_flush),
        .d     (issue_in),
        .q     (issue_q)
    );

    div_core u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (wb_flush),
        .out_stall (wb_stall),
        .req       (issue_q),
        .busy      (div_busy),
        .done_out  (done_out)
    );

    // wb_stall is also the core's back-pressure
    div_pipe_reg #(
        .payload_t (div_wb_t)
    ) u_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (wb_stall),
        .flush (wb_flush),
        .d     (done_out),
        .q     (wb_out)
    );

endmodule

// ==== dv/exec_div_chk.sv ====
`timescale 1ns/1ps

module exec_div_chk (
    input logic                 clk,
    input logic                 rst_n,
    input div_pkg::exec_issue_t issue_q,
    input div_pkg::div_state_e  core_state,
    input logic                 done_valid,
    input logic                 ex_flush,
    input logic                 wb_stall,
    input logic                 wb_flush,
    input logic                 div_busy,
    input div_pkg::div_wb_t     wb_out
);
    import div_pkg::*;

    logic                 accept;
    logic                 transfer;
    logic                 pending;
    logic [xlen-1:0]      exp_result;
    logic [reg_idx_w-1:0] exp_rd;

    // details of the first failure for the testbench
    bit              fail_flag;
    bit              fail_value;
    string           fail_msg;
    time             fail_time;
    logic [xlen-1:0] fail_got;
    logic [xlen-1:0] fail_exp;

    // quotient truncates toward zero and remainder keeps the dividend sign
    function automatic logic [xlen-1:0] expected_result(div_op_e op, logic [xlen-1:0] a,
                                                        logic [xlen-1:0] b);
        logic            is_signed;
        logic            is_rem;
        logic [xlen-1:0] q;
        logic [xlen-1:0] r;
        is_signed = (op == op_div) || (op == op_mod);
        is_rem    = (op == op_mod) || (op == op_modu);
        if (b == '0)
        begin
            q = '0;
            r = a;
        end
        else if (is_signed && (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1))
        begin
            q = a;
            r = '0;
        end
        else if (is_signed)
        begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end
        else
        begin
            q = a / b;
            r = a % b;
        end
        return is_rem ? r : q;
    endfunction

    task automatic note_mismatch(string sig, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        if (!fail_flag)
        begin
            fail_value = 1'b1;
            fail_msg   = sig;
            fail_time  = $time;
            fail_got   = got;
            fail_exp   = exp;
            fail_flag  = 1'b1;
        end
    endtask

    task automatic note_violation(string msg);
        if (!fail_flag)
        begin
            fail_value = 1'b0;
            fail_msg   = msg;
            fail_time  = $time;
            fail_flag  = 1'b1;
        end
    endtask

    assign accept = (core_state == st_idle) && issue_q.valid && (issue_q.fu_type == fu_div)
                    && !wb_stall;
    assign transfer = done_valid && !wb_stall;

    // one outstanding request until flush or writeback takes it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending    <= 1'b0;
            exp_result <= '0;
            exp_rd     <= '0;
        end
        else if (wb_flush)
        begin
            pending <= 1'b0;
        end
        else if (accept)
        begin
            pending    <= 1'b1;
            exp_result <= expected_result(issue_q.op, issue_q.src1, issue_q.src2);
            exp_rd     <= issue_q.rd;
        end
        else if (wb_out.valid && !wb_stall)
        begin
            pending <= 1'b0;
        end
    end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        wb_out.valid |-> (wb_out.result == exp_result))
    else
    begin
        note_mismatch("wb_out.result", $sampled(wb_out.result), $sampled(exp_result));
        $error("divider result mismatch");
    end

    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        wb_out.valid |-> (wb_out.rd == exp_rd))
    else
    begin
        note_mismatch("wb_out.rd", $sampled(wb_out.rd), $sampled(exp_rd));
        $error("destination register mismatch");
    end

    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n || wb_flush)
        accept |=> div_busy)
    else
    begin
        note_violation("div_busy did not rise after an accepted request");
        $error("busy missing after accept");
    end

    a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (pending && !wb_out.valid && !transfer) |-> div_busy)
    else
    begin
        note_violation("div_busy dropped before the result was taken");
        $error("busy dropped early");
    end

    a_single: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (!pending || wb_out.valid))
    else
    begin
        note_violation("a second request was accepted while one was outstanding");
        $error("double accept");
    end

    a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        wb_out.valid |-> pending)
    else
    begin
        note_violation("wb_out.valid without an outstanding accepted request");
        $error("unexpected result");
    end

    a_once: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_out.valid && !wb_stall) |=> !wb_out.valid)
    else
    begin
        note_violation("the same result was written back twice");
        $error("repeated result");
    end

    a_stall_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stall && !wb_flush) |=> (wb_out.valid == $past(wb_out.valid)))
    else
    begin
        note_violation("wb_out.valid changed while wb_stall was high");
        $error("writeback moved under stall");
    end

    a_stall_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stall && !wb_flush && wb_out.valid) |=> (wb_out == $past(wb_out)))
    else
    begin
        note_violation("wb_out contents changed while wb_stall was high");
        $error("writeback data moved under stall");
    end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        wb_flush |=> (!div_busy && !wb_out.valid))
    else
    begin
        note_violation("divider still busy or valid after wb_flush");
        $error("flush did not clear the unit");
    end

    a_kill: assert property (@(posedge clk) disable iff (!rst_n)
        ex_flush |=> !issue_q.valid)
    else
    begin
        note_violation("issue stage kept a request killed by ex_flush");
        $error("ex_flush ignored");
    end

    a_foreign: assert property (@(posedge clk) disable iff (!rst_n)
        ((core_state == st_idle) && issue_q.valid && (issue_q.fu_type != fu_div))
        |=> !div_busy)
    else
    begin
        note_violation("divider accepted a request for another functional unit");
        $error("foreign request accepted");
    end

    a_reset: assert property (@(posedge clk)
        !rst_n |-> (!div_busy && !wb_out.valid))
    else
    begin
        note_violation("div_busy or wb_out.valid high during reset");
        $error("outputs not cleared by reset");
    end

endmodule

bind exec_div_top exec_div_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue_q    (issue_q),
    .core_state (u_core.state_q),
    .done_valid (done_out.valid),
    .ex_flush   (ex_flush),
    .wb_stall   (wb_stall),
    .wb_flush   (wb_flush),
    .div_busy   (div_busy),
    .wb_out     (wb_out)
);

// ==== dv/tb_exec_div.sv ====
`timescale 1ns/1ps

module tb_exec_div;
    import div_pkg::*;

    localparam int n_ops          = 300;
    localparam int result_timeout = 100;

    logic        clk;
    logic        rst_n;
    exec_issue_t issue_in;
    logic        ex_stall;
    logic        ex_flush;
    logic        wb_stall;
    logic        wb_flush;
    logic        div_busy;
    div_wb_t     wb_out;

    integer seed;
    int     op_count;

    exec_div_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue_in (issue_in),
        .ex_stall (ex_stall),
        .ex_flush (ex_flush),
        .wb_stall (wb_stall),
        .wb_flush (wb_flush),
        .div_busy (div_busy),
        .wb_out   (wb_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_on_assertion();
        if (uut.u_chk.fail_value)
            $display("FAIL at %0t: %s = %h, expected %h", uut.u_chk.fail_time,
                     uut.u_chk.fail_msg, uut.u_chk.fail_got, uut.u_chk.fail_exp);
        else
            $display("check failed at %0t: %s", uut.u_chk.fail_time, uut.u_chk.fail_msg);
        $display("Test FAILED");
        $fatal(1, "divider check failed");
    endtask

    always @(posedge clk)
    begin
        if (uut.u_chk.fail_flag)
            stop_on_assertion();
    end

    // request stays on issue_in while the issue stage is stalled
    task automatic send_req(input div_op_e op, input logic [xlen-1:0] a,
                            input logic [xlen-1:0] b, input logic [reg_idx_w-1:0] rd,
                            input logic [fu_type_w-1:0] fu, input bit kill,
                            input int issue_stall);
        issue_in.valid   = 1'b1;
        issue_in.fu_type = fu;
        issue_in.op      = op;
        issue_in.src1    = a;
        issue_in.src2    = b;
        issue_in.rd      = rd;
        ex_stall = (issue_stall > 0);
        repeat (issue_stall)
            tick();
        ex_stall = 1'b0;
        ex_flush = kill;
        tick();
        issue_in.valid = 1'b0;
        ex_flush       = 1'b0;
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (!wb_out.valid && (cycles < result_timeout))
        begin
            tick();
            cycles++;
        end
        if (!wb_out.valid)
        begin
            $display("no divider result within %0d cycles at %0t", result_timeout, $time);
            $display("Test FAILED");
            $fatal(1, "result timeout");
        end
    endtask

    task automatic run_op(input div_op_e op, input logic [xlen-1:0] a,
                          input logic [xlen-1:0] b, input int issue_stall,
                          input int out_stall);
        logic [reg_idx_w-1:0] rd;
        rd = reg_idx_w'($random(seed));
        send_req(op, a, b, rd, fu_div, 1'b0, issue_stall);
        if (out_stall > 0)
        begin
            // accepted on this edge, then back-pressure the finish
            tick();
            wb_stall = 1'b1;
            repeat (out_stall)
                tick();
            wb_stall = 1'b0;
        end
        wait_result();
        if (out_stall > 0)
        begin
            wb_stall = 1'b1;
            repeat (2)
                tick();
            wb_stall = 1'b0;
        end
        op_count++;
    endtask

    // second request waits in the issue stage behind a busy divider
    task automatic run_pair(input div_op_e op_a, input logic [xlen-1:0] a1,
                            input logic [xlen-1:0] b1, input div_op_e op_b,
                            input logic [xlen-1:0] a2, input logic [xlen-1:0] b2);
        logic [reg_idx_w-1:0] rd;
        rd = reg_idx_w'($random(seed));
        send_req(op_a, a1, b1, rd, fu_div, 1'b0, 0);
        issue_in.valid = 1'b1;
        issue_in.op    = op_b;
        issue_in.src1  = a2;
        issue_in.src2  = b2;
        issue_in.rd    = rd + 1'b1;
        wait_result();
        issue_in.valid = 1'b0;
        tick();
        wait_result();
        op_count += 2;
    endtask

    initial
    begin
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [31:0]     kind;
        logic [31:0]     opr;
        int              i;

        seed     = 42;
        op_count = 0;
        rst_n    = 1'b0;
        issue_in = '0;
        ex_stall = 1'b0;
        ex_flush = 1'b0;
        wb_stall = 1'b0;
        wb_flush = 1'b0;
        repeat (16)
            tick();
        rst_n = 1'b1;
        tick();

        // all sign combinations on every op
        for (i = 0; i < 4; i++)
        begin
            a = i[0] ? -32'd100 : 32'd100;
            b = i[1] ? -32'd7 : 32'd7;
            run_op(op_div, a, b, 0, 0);
            run_op(op_mod, a, b, 0, 0);
            run_op(op_divu, a, b, 0, 0);
            run_op(op_modu, a, b, 0, 0);
        end

        // zero divisor with positive and negative dividends
        for (i = 0; i < 2; i++)
        begin
            a = i[0] ? 32'hffff_fffb : 32'h1234_5678;
            run_op(op_div, a, '0, 0, 0);
            run_op(op_mod, a, '0, 0, 0);
            run_op(op_divu, a, '0, 0, 0);
            run_op(op_modu, a, '0, 0, 0);
        end

        run_op(op_div, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        run_op(op_mod, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        run_op(op_divu, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        run_op(op_div, 32'h8000_0000, 32'd1, 0, 0);
        run_op(op_mod, 32'd3, 32'h7fff_ffff, 0, 0);
        run_op(op_divu, 32'hffff_ffff, 32'd1, 0, 0);
        run_op(op_modu, 32'd5, 32'hffff_ffff, 0, 0);
        run_op(op_div, 32'd1, 32'd1, 0, 0);
        run_op(op_div, 32'd1000, -32'd3, 3, 0);
        run_op(op_divu, 32'hdead_beef, 32'd3, 0, 40);
        run_op(op_mod, -32'd12345, 32'd17, 0, 2);

        // next request arrives while the first one divides
        run_pair(op_divu, 32'hffff_ffff, 32'd1, op_mod, -32'd77, 32'd5);
        run_pair(op_div, -32'd9, '0, op_divu, 32'd40, 32'd6);

        // writeback flush in the middle of a long division
        send_req(op_divu, 32'hffff_ffff, 32'd1, 5'd7, fu_div, 1'b0, 0);
        repeat (6)
            tick();
        wb_flush = 1'b1;
        tick();
        wb_flush = 1'b0;
        repeat (40)
            tick();

        // other functional unit, then a request killed in issue
        send_req(op_div, 32'd50, 32'd5, 5'd3, 4'd1, 1'b0, 0);
        repeat (40)
            tick();
        send_req(op_div, 32'd50, 32'd5, 5'd4, fu_div, 1'b1, 0);
        repeat (40)
            tick();

        // reset while busy
        send_req(op_divu, 32'hffff_ffff, 32'd3, 5'd9, fu_div, 1'b0, 0);
        repeat (4)
            tick();
        rst_n = 1'b0;
        repeat (16)
            tick();
        rst_n = 1'b1;
        repeat (4)
            tick();

        while (op_count < n_ops)
        begin
            kind = $random(seed);
            a    = $random(seed);
            b    = $random(seed);
            opr  = $random(seed);
            case (kind[2:0])
                3'd0: b = b & 32'h0000_00ff;
                3'd1: a = a & 32'h0000_00ff;
                3'd2: b = '0;
                3'd3:
                begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end
                default:
                begin
                end
            endcase
            run_op(div_op_e'({3'b000, opr[1:0]}), a, b, 0, (kind[5:3] == 3'd0) ? 5 : 0);
        end

        repeat (4)
            tick();
        if (uut.u_chk.fail_flag)
            stop_on_assertion();
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== build.f ====
source/div_pkg.sv
source/lead_one_finder.sv
source/div_pipe_reg.sv
source/div_core.sv
source/exec_div_top.sv
dv/exec_div_chk.sv
dv/tb_exec_div.sv
